// File: logic/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Datapath and operand width.
`define EXEC_DATA_W 32

// Destination register select.
`define EXEC_RD_SEL_W 4

// Control register select and number of slots.
`define EXEC_CR_SEL_W 3
`define EXEC_CR_COUNT 8

// Upper vector base bits kept, 64 byte aligned.
`define EXEC_VECTOR_W 26

`endif

// File: logic/exec_pkg.sv
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

	typedef enum logic [4:0] {
		ALU_OPC_ADD   = 5'h00,
		ALU_OPC_ADDC  = 5'h01,
		ALU_OPC_SUB   = 5'h02,
		ALU_OPC_SUBC  = 5'h03,
		ALU_OPC_MUL   = 5'h04,
		ALU_OPC_LSL   = 5'h05,
		ALU_OPC_LSR   = 5'h06,
		ALU_OPC_ASR   = 5'h07,
		ALU_OPC_AND   = 5'h08,
		ALU_OPC_OR    = 5'h09,
		ALU_OPC_XOR   = 5'h0a,
		ALU_OPC_BIC   = 5'h0b,
		ALU_OPC_BST   = 5'h0c,
		ALU_OPC_COPYA = 5'h0d,
		ALU_OPC_COPYB = 5'h0e,
		ALU_OPC_CMP   = 5'h0f,
		ALU_OPC_MOVHI = 5'h10,
		ALU_OPC_GCR   = 5'h11,
		ALU_OPC_SWI   = 5'h12,
		ALU_OPC_RFE   = 5'h13
	} alu_opc_t;

	typedef enum logic [3:0] {
		BRANCH_CC_NONE = 4'h0,
		BRANCH_CC_NE   = 4'h1,
		BRANCH_CC_EQ   = 4'h2,
		BRANCH_CC_GT   = 4'h3,
		BRANCH_CC_LT   = 4'h4,
		BRANCH_CC_GTS  = 4'h5,
		BRANCH_CC_LTS  = 4'h6,
		BRANCH_CC_B    = 4'h7,
		BRANCH_CC_GTE  = 4'h8,
		BRANCH_CC_GTES = 4'h9,
		BRANCH_CC_LTE  = 4'ha,
		BRANCH_CC_LTES = 4'hb
	} branch_cc_t;

	typedef enum logic [1:0] {
		CLASS_ALU    = 2'h0,
		CLASS_MEM    = 2'h1,
		CLASS_BRANCH = 2'h2,
		CLASS_OTHER  = 2'h3
	} instr_class_t;

	typedef struct packed {
		logic tlb_en;
		logic icache_en;
		logic dcache_en;
		logic irq_en;
		logic n;
		logic o;
		logic c;
		logic z;
	} psr_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
		logic o;
	} alu_flags_t;

	typedef struct packed {
		logic [`EXEC_DATA_W-1:0]   ra;
		logic [`EXEC_DATA_W-1:0]   rb;
		logic [`EXEC_DATA_W-1:0]   imm32;
		logic [`EXEC_DATA_W-1:0]   pc_plus_4;
		logic [`EXEC_RD_SEL_W-1:0] rd_sel;
		logic                      update_rd;
		alu_opc_t                  alu_opc;
		logic                      op1_ra;
		logic                      op1_rb;
		logic                      op2_rb;
		logic                      mem_load;
		logic                      mem_store;
		logic [1:0]                mem_width;
		branch_cc_t                branch_cc;
		instr_class_t              instr_class;
		logic                      update_carry;
		logic                      update_flags;
		logic                      is_call;
		logic                      is_swi;
		logic                      is_rfe;
		logic                      valid;
		logic [`EXEC_CR_SEL_W-1:0] cr_sel;
		logic                      write_cr;
	} exec_req_t;

	typedef struct packed {
		logic                    exception_start;
		logic                    irq_start;
		logic                    data_abort;
		logic                    disable_irqs;
		logic                    disable_mmu;
		logic [`EXEC_DATA_W-1:0] fault_address;
	} exc_ev_t;

	typedef struct packed {
		logic [`EXEC_DATA_W-1:0]   alu_out;
		logic [`EXEC_DATA_W-1:0]   wr_val;
		logic                      wr_result;
		logic [`EXEC_RD_SEL_W-1:0] rd_sel;
		logic                      branch_taken;
		logic                      stall_clear;
		logic                      valid;
	} exec_out_t;

	typedef struct packed {
		logic                    load;
		logic                    store;
		logic                    wr_en;
		logic [1:0]              width;
		logic [`EXEC_DATA_W-1:0] mar;
		logic [`EXEC_DATA_W-1:0] mdr;
	} mem_req_t;

endpackage

`default_nettype wire

// File: logic/exec_alu.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_alu
	import exec_pkg::*;
(
	input  wire exec_req_t                 i_req,
	input  wire                            i_carry,
	input  wire [`EXEC_DATA_W-1:0]         i_cr_val,
	input  wire [`EXEC_VECTOR_W-1:0]       i_vector_base,
	input  wire [`EXEC_DATA_W-1:0]         i_fault_address,
	output logic [`EXEC_DATA_W-1:0]        o_result,
	output alu_flags_t                     o_flags
);

	localparam int SHAMT_W = $clog2(`EXEC_DATA_W);
	localparam int HALF_W = `EXEC_DATA_W / 2;
	localparam int VEC_OFF_W = `EXEC_DATA_W - `EXEC_VECTOR_W;
	localparam logic [VEC_OFF_W-1:0] SWI_OFFSET = 8;
	localparam logic [`EXEC_DATA_W-1:0] ONE = 1;
	localparam int MSB = `EXEC_DATA_W - 1;

	logic [`EXEC_DATA_W-1:0] op1;
	logic [`EXEC_DATA_W-1:0] op2;
	logic [`EXEC_DATA_W-1:0] q;
	logic [SHAMT_W-1:0]      shamt;
	logic                    c;
	logic                    o;

	assign op1 = i_req.op1_ra ? i_req.ra : i_req.op1_rb ? i_req.rb : i_req.pc_plus_4;
	assign op2 = i_req.op2_rb ? i_req.rb : i_req.imm32;
	assign shamt = op2[SHAMT_W-1:0];

	always_comb begin
		c = 1'b0;
		o = 1'b0;
		q = '0;
		case (i_req.alu_opc)
		ALU_OPC_ADD, ALU_OPC_ADDC: begin
			{c, q} = {1'b0, op1} + {1'b0, op2} +
				{{`EXEC_DATA_W{1'b0}}, i_req.alu_opc == ALU_OPC_ADDC && i_carry};
			o = (op1[MSB] == op2[MSB]) && (q[MSB] != op1[MSB]);
		end
		ALU_OPC_SUB, ALU_OPC_SUBC, ALU_OPC_CMP: begin
			{c, q} = {1'b0, op1} - {1'b0, op2} -
				{{`EXEC_DATA_W{1'b0}}, i_req.alu_opc == ALU_OPC_SUBC && i_carry};
			o = (op1[MSB] != op2[MSB]) && (q[MSB] != op1[MSB]);
			if (i_req.alu_opc == ALU_OPC_CMP)
				c = ~c; // Set means no borrow.
		end
		ALU_OPC_MUL:   {c, q} = {1'b0, op1} * {1'b0, op2};
		ALU_OPC_LSL:   {c, q} = {1'b0, op1} << shamt;
		ALU_OPC_LSR:   q = op1 >> shamt;
		ALU_OPC_ASR:   q = $signed(op1) >>> shamt;
		ALU_OPC_AND:   q = op1 & op2;
		ALU_OPC_OR:    q = op1 | op2;
		ALU_OPC_XOR:   q = op1 ^ op2;
		ALU_OPC_BIC:   q = op1 & ~(ONE << shamt);
		ALU_OPC_BST:   q = op1 | (ONE << shamt);
		ALU_OPC_COPYA: q = op1;
		ALU_OPC_COPYB: q = op2;
		ALU_OPC_MOVHI: q = op1 | {{HALF_W{1'b0}}, op2[HALF_W-1:0]};
		ALU_OPC_GCR:   q = i_cr_val;
		ALU_OPC_SWI:   q = {i_vector_base, SWI_OFFSET}; // Software interrupt slot.
		ALU_OPC_RFE:   q = i_fault_address; // Return address.
		default:       q = '0;
		endcase
	end

	assign o_result = q;

	// Zero compares the operands, so CMP and SUB both report equality.
	assign o_flags.c = c;
	assign o_flags.z = op1 == op2;
	assign o_flags.n = q[MSB];
	assign o_flags.o = o;

endmodule

`default_nettype wire

// File: logic/exec_branch_cond.sv
`default_nettype none
`timescale 1ns/1ps

module exec_branch_cond
	import exec_pkg::*;
(
	input  wire branch_cc_t i_cc,
	input  wire psr_t       i_psr,
	output logic            o_condition_met
);

	logic signed_ge;

	assign signed_ge = i_psr.n == i_psr.o;

	always_comb begin
		case (i_cc)
		BRANCH_CC_NE:   o_condition_met = !i_psr.z;
		BRANCH_CC_EQ:   o_condition_met = i_psr.z;
		BRANCH_CC_GT:   o_condition_met = i_psr.c && !i_psr.z; // Unsigned.
		BRANCH_CC_LT:   o_condition_met = !i_psr.c;
		BRANCH_CC_GTS:  o_condition_met = signed_ge && !i_psr.z;
		BRANCH_CC_LTS:  o_condition_met = !signed_ge;
		BRANCH_CC_B:    o_condition_met = 1'b1;
		BRANCH_CC_GTE:  o_condition_met = i_psr.c;
		BRANCH_CC_GTES: o_condition_met = signed_ge;
		BRANCH_CC_LTE:  o_condition_met = !i_psr.c || i_psr.z;
		BRANCH_CC_LTES: o_condition_met = !signed_ge || i_psr.z;
		default:        o_condition_met = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/exec_ctrl_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_ctrl_regs
	import exec_pkg::*;
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire exec_req_t               i_req,
	input  wire alu_flags_t              i_flags,
	input  wire exc_ev_t                 i_exc,
	input  wire [`EXEC_DATA_W-1:0]       i_mar,
	input  wire [`EXEC_CR_SEL_W-1:0]     i_dbg_cr_sel,
	input  wire [`EXEC_DATA_W-1:0]       i_dbg_cr_wr_val,
	input  wire                          i_dbg_cr_wr_en,
	output psr_t                         o_psr,
	output logic [`EXEC_DATA_W-1:0]      o_cr_val,
	output logic [`EXEC_DATA_W-1:0]      o_dbg_cr_val,
	output logic [`EXEC_VECTOR_W-1:0]    o_vector_base,
	output logic [`EXEC_DATA_W-1:0]      o_fault_address
);

	localparam int CR_VECTOR = 0;
	localparam int CR_PSR = 1;
	localparam int CR_SAVED_PSR = 2;
	localparam int CR_FAULT = 3;
	localparam int CR_DATA_FAULT = 4;
	localparam int VEC_OFF_W = `EXEC_DATA_W - `EXEC_VECTOR_W;
	localparam int PSR_W = $bits(psr_t);

	logic [`EXEC_CR_COUNT-1:0] dbg_wr;
	logic [`EXEC_CR_COUNT-1:0] cr_wr;
	logic                      exc_any;
	logic [`EXEC_VECTOR_W-1:0] vector_base;
	psr_t                      psr;
	psr_t                      saved_psr;
	logic [`EXEC_DATA_W-1:0]   fault_address;
	logic [`EXEC_DATA_W-1:0]   data_fault_address;
	logic [`EXEC_DATA_W-1:0]   cr_file [`EXEC_CR_COUNT];

	assign dbg_wr = i_dbg_cr_wr_en ? `EXEC_CR_COUNT'(1) << i_dbg_cr_sel : '0;
	assign cr_wr = i_req.write_cr ? `EXEC_CR_COUNT'(1) << i_req.cr_sel : '0;
	assign exc_any = i_exc.exception_start || i_exc.irq_start || i_exc.data_abort ||
		i_exc.disable_irqs || i_exc.disable_mmu;

	always_ff @(posedge clk) begin
		if (rst)
			vector_base <= '0;
		else if (dbg_wr[CR_VECTOR])
			vector_base <= i_dbg_cr_wr_val[`EXEC_DATA_W-1:VEC_OFF_W];
		else if (cr_wr[CR_VECTOR])
			vector_base <= i_req.ra[`EXEC_DATA_W-1:VEC_OFF_W];
	end

	// Instruction write wins over the debugger for the PSR.
	always_ff @(posedge clk) begin
		if (rst) begin
			psr <= '0;
		end else if (cr_wr[CR_PSR]) begin
			psr <= i_req.ra[PSR_W-1:0];
		end else if (dbg_wr[CR_PSR]) begin
			psr <= i_dbg_cr_wr_val[PSR_W-1:0];
		end else if (i_req.is_rfe) begin
			psr <= saved_psr;
		end else begin
			if (i_exc.disable_irqs)
				psr.irq_en <= 1'b0;
			if (i_exc.disable_mmu)
				psr.tlb_en <= 1'b0;
			if (i_req.update_flags) begin
				psr.z <= i_flags.z;
				psr.n <= i_flags.n;
				psr.o <= i_flags.o;
			end
			if (i_req.update_carry)
				psr.c <= i_flags.c;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			saved_psr <= '0;
		else if (dbg_wr[CR_SAVED_PSR])
			saved_psr <= i_dbg_cr_wr_val[PSR_W-1:0];
		else if (exc_any)
			saved_psr <= psr;
		else if (cr_wr[CR_SAVED_PSR])
			saved_psr <= i_req.ra[PSR_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			fault_address <= '0;
		else if (dbg_wr[CR_FAULT])
			fault_address <= i_dbg_cr_wr_val;
		else if (i_exc.irq_start)
			fault_address <= i_exc.fault_address;
		else if (i_exc.disable_irqs || i_exc.disable_mmu)
			fault_address <= i_req.pc_plus_4; // Resume after the trapping instruction.
		else if (cr_wr[CR_FAULT])
			fault_address <= i_req.ra;
	end

	always_ff @(posedge clk) begin
		if (rst)
			data_fault_address <= '0;
		else if (dbg_wr[CR_DATA_FAULT])
			data_fault_address <= i_dbg_cr_wr_val;
		else if (i_exc.data_abort)
			data_fault_address <= i_mar;
		else if (cr_wr[CR_DATA_FAULT])
			data_fault_address <= i_req.ra;
	end

	always_comb begin
		for (int i = 0; i < `EXEC_CR_COUNT; i++)
			cr_file[i] = '0; // Unimplemented slots.
		cr_file[CR_VECTOR] = {vector_base, {VEC_OFF_W{1'b0}}};
		cr_file[CR_PSR] = `EXEC_DATA_W'(psr);
		cr_file[CR_SAVED_PSR] = `EXEC_DATA_W'(saved_psr);
		cr_file[CR_FAULT] = fault_address;
		cr_file[CR_DATA_FAULT] = data_fault_address;
	end

	assign o_cr_val = cr_file[i_req.cr_sel];
	assign o_dbg_cr_val = cr_file[i_dbg_cr_sel];
	assign o_psr = psr;
	assign o_vector_base = vector_base;
	assign o_fault_address = fault_address;

endmodule

`default_nettype wire

// File: logic/exec_result_reg.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_result_reg
	import exec_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst,
	input  wire exec_req_t         i_req,
	input  wire [`EXEC_DATA_W-1:0] i_alu_result,
	input  wire                    i_condition_met,
	output exec_out_t              o_out,
	output mem_req_t               o_mem
);

	logic [`EXEC_DATA_W-1:0]   alu_out;
	logic [`EXEC_DATA_W-1:0]   wr_val;
	logic [`EXEC_RD_SEL_W-1:0] rd_sel;
	logic                      wr_result;
	logic                      branch_taken;
	logic                      stall_clear;
	logic                      valid;
	logic                      load;
	logic                      store;
	logic                      wr_en;
	logic [1:0]                width;
	logic [`EXEC_DATA_W-1:0]   mar;
	logic [`EXEC_DATA_W-1:0]   mdr;

	always_ff @(posedge clk) begin
		alu_out <= i_alu_result;
		rd_sel <= i_req.rd_sel;
		wr_val <= i_req.is_call ? i_req.pc_plus_4 :
			i_req.mem_store ? i_req.rb : i_alu_result; // Link, store data or result.
		if (i_req.mem_load || i_req.mem_store) begin
			width <= i_req.mem_width;
			mar <= i_alu_result;
			if (i_req.mem_store)
				mdr <= i_req.rb;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_result <= 1'b0;
			branch_taken <= 1'b0;
			stall_clear <= 1'b0;
			valid <= 1'b0;
			load <= 1'b0;
			store <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			wr_result <= i_req.update_rd;
			branch_taken <= i_req.instr_class == CLASS_BRANCH &&
				(i_condition_met || i_req.is_swi || i_req.is_rfe);
			// GCR in the memory class reads state the pipeline may not see yet.
			stall_clear <= i_req.instr_class == CLASS_BRANCH || i_req.write_cr ||
				(i_req.instr_class == CLASS_MEM && i_req.alu_opc == ALU_OPC_GCR);
			valid <= i_req.valid;
			load <= i_req.mem_load;
			store <= i_req.mem_store;
			wr_en <= i_req.mem_store;
		end
	end

	assign o_out = '{alu_out: alu_out, wr_val: wr_val, wr_result: wr_result,
		rd_sel: rd_sel, branch_taken: branch_taken, stall_clear: stall_clear,
		valid: valid};
	assign o_mem = '{load: load, store: store, wr_en: wr_en, width: width,
		mar: mar, mdr: mdr};

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_stage
	import exec_pkg::*;
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire exec_req_t               i_req,
	input  wire exc_ev_t                 i_exc,
	input  wire [`EXEC_CR_SEL_W-1:0]     i_dbg_cr_sel,
	input  wire [`EXEC_DATA_W-1:0]       i_dbg_cr_wr_val,
	input  wire                          i_dbg_cr_wr_en,
	output wire exec_out_t               o_out,
	output wire mem_req_t                o_mem,
	output wire psr_t                    o_psr,
	output wire [`EXEC_VECTOR_W-1:0]     o_vector_base,
	output wire [`EXEC_DATA_W-1:0]       o_dbg_cr_val
);

	wire [`EXEC_DATA_W-1:0] alu_result;
	wire alu_flags_t        alu_flags;
	wire [`EXEC_DATA_W-1:0] cr_val;
	wire [`EXEC_DATA_W-1:0] fault_address;
	wire                    condition_met;

	exec_alu alu_i (.i_req(i_req), .i_carry(o_psr.c), .i_cr_val(cr_val),
		.i_vector_base(o_vector_base), .i_fault_address(fault_address),
		.o_result(alu_result), .o_flags(alu_flags));

	exec_branch_cond branch_cond_i (.i_cc(i_req.branch_cc), .i_psr(o_psr),
		.o_condition_met(condition_met));

	exec_ctrl_regs ctrl_regs_i (.clk(clk), .rst(rst), .i_req(i_req), .i_flags(alu_flags),
		.i_exc(i_exc), .i_mar(o_mem.mar), .i_dbg_cr_sel(i_dbg_cr_sel),
		.i_dbg_cr_wr_val(i_dbg_cr_wr_val), .i_dbg_cr_wr_en(i_dbg_cr_wr_en),
		.o_psr(o_psr), .o_cr_val(cr_val), .o_dbg_cr_val(o_dbg_cr_val),
		.o_vector_base(o_vector_base), .o_fault_address(fault_address));

	exec_result_reg result_reg_i (.clk(clk), .rst(rst), .i_req(i_req),
		.i_alu_result(alu_result), .i_condition_met(condition_met),
		.o_out(o_out), .o_mem(o_mem));

endmodule

`default_nettype wire

// File: tests/exec_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module exec_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk; // 100 ns period.
	end

	initial begin
		o_rst = 1'b1;
		repeat (2) @(posedge o_clk);
		@(negedge o_clk);
		o_rst <= 1'b0; // Released on a falling edge.
	end

endmodule

`default_nettype wire

// File: tests/exec_stage_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_stage_tb
	import exec_pkg::*;
();

	localparam int VEC_LSB = `EXEC_DATA_W - `EXEC_VECTOR_W;

	logic                        clk;
	logic                        rst;
	exec_req_t                   req;
	exc_ev_t                     exc;
	logic [`EXEC_CR_SEL_W-1:0]   dbg_sel;
	logic [`EXEC_DATA_W-1:0]     dbg_val;
	logic                        dbg_en;
	exec_out_t                   o_out;
	mem_req_t                    o_mem;
	psr_t                        o_psr;
	logic [`EXEC_VECTOR_W-1:0]   o_vector_base;
	logic [`EXEC_DATA_W-1:0]     o_dbg_cr_val;

	// Reference model state.
	logic [`EXEC_VECTOR_W-1:0]   m_vec;
	psr_t                        m_psr;
	psr_t                        m_saved;
	logic [`EXEC_DATA_W-1:0]     m_fault;
	logic [`EXEC_DATA_W-1:0]     m_dfault;
	logic [`EXEC_DATA_W-1:0]     m_mar;
	logic [`EXEC_DATA_W-1:0]     m_mdr;
	logic [1:0]                  m_width;

	int    checks;
	int    errors;
	string test_name;
	logic  released;
	int    seed_val;

	exec_clock_gen clock_gen_i (.o_clk(clk), .o_rst(rst));

	exec_stage dut_i (.clk(clk), .rst(rst), .i_req(req), .i_exc(exc),
		.i_dbg_cr_sel(dbg_sel), .i_dbg_cr_wr_val(dbg_val), .i_dbg_cr_wr_en(dbg_en),
		.o_out(o_out), .o_mem(o_mem), .o_psr(o_psr), .o_vector_base(o_vector_base),
		.o_dbg_cr_val(o_dbg_cr_val));

	task automatic check_value(input string field, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", test_name, field, exp, act);
		end
	endtask

	function automatic logic [31:0] cr_read(input logic [2:0] sel);
		case (sel)
		3'd0: return {m_vec, {VEC_LSB{1'b0}}};
		3'd1: return 32'(m_psr);
		3'd2: return 32'(m_saved);
		3'd3: return m_fault;
		3'd4: return m_dfault;
		default: return '0; // Not implemented.
		endcase
	endfunction

	function automatic logic cond_met(input branch_cc_t cc, input psr_t p);
		case (cc)
		BRANCH_CC_NE:   return !p.z;
		BRANCH_CC_EQ:   return p.z;
		BRANCH_CC_GT:   return p.c && !p.z;
		BRANCH_CC_LT:   return !p.c;
		BRANCH_CC_GTS:  return (p.n == p.o) && !p.z;
		BRANCH_CC_LTS:  return p.n != p.o;
		BRANCH_CC_B:    return 1'b1;
		BRANCH_CC_GTE:  return p.c;
		BRANCH_CC_GTES: return p.n == p.o;
		BRANCH_CC_LTE:  return !p.c || p.z;
		BRANCH_CC_LTES: return (p.n != p.o) || p.z;
		default:        return 1'b0;
		endcase
	endfunction

	function automatic void model_alu(input exec_req_t r, output logic [31:0] res,
		output alu_flags_t fl);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] q;
		logic [63:0] wide;
		logic        cin;
		longint      sa;
		longint      sb;
		longint      ss;
		int unsigned sh;
		a = r.op1_ra ? r.ra : (r.op1_rb ? r.rb : r.pc_plus_4);
		b = r.op2_rb ? r.rb : r.imm32;
		sh = b % 32;
		sa = $signed(a);
		sb = $signed(b);
		cin = (r.alu_opc == ALU_OPC_ADDC || r.alu_opc == ALU_OPC_SUBC) && m_psr.c;
		fl = '0;
		q = '0;
		case (r.alu_opc)
		ALU_OPC_ADD, ALU_OPC_ADDC: begin
			wide = 64'(a) + 64'(b) + 64'(cin);
			q = wide[31:0];
			fl.c = wide[32];
			ss = sa + sb + longint'(cin);
			fl.o = ss != longint'($signed(q));
		end
		ALU_OPC_SUB, ALU_OPC_SUBC, ALU_OPC_CMP: begin
			q = a - b - 32'(cin);
			fl.c = 64'(a) < 64'(b) + 64'(cin); // Borrow.
			if (r.alu_opc == ALU_OPC_CMP)
				fl.c = !fl.c;
			ss = sa - sb - longint'(cin);
			fl.o = ss != longint'($signed(q));
		end
		ALU_OPC_MUL: begin
			wide = 64'(a) * 64'(b);
			q = wide[31:0];
			fl.c = wide[32];
		end
		ALU_OPC_LSL: begin
			wide = 64'(a) << sh;
			q = wide[31:0];
			fl.c = wide[32];
		end
		ALU_OPC_LSR:   q = a >> sh;
		ALU_OPC_ASR:   q = 32'(sa >>> sh);
		ALU_OPC_AND:   q = a & b;
		ALU_OPC_OR:    q = a | b;
		ALU_OPC_XOR:   q = a ^ b;
		ALU_OPC_BIC: begin
			q = a;
			q[sh] = 1'b0;
		end
		ALU_OPC_BST: begin
			q = a;
			q[sh] = 1'b1;
		end
		ALU_OPC_COPYA: q = a;
		ALU_OPC_COPYB: q = b;
		ALU_OPC_MOVHI: q = a | {16'h0000, b[15:0]};
		ALU_OPC_GCR:   q = cr_read(r.cr_sel);
		ALU_OPC_SWI:   q = {m_vec, 6'd8};
		ALU_OPC_RFE:   q = m_fault;
		default:       q = '0;
		endcase
		fl.n = q[31];
		fl.z = a == b;
		res = q;
	endfunction

	function automatic logic dbg_writes(input int sel);
		return dbg_en && dbg_sel == sel;
	endfunction

	function automatic logic ins_writes(input int sel);
		return req.write_cr && req.cr_sel == sel;
	endfunction

	task automatic update_ctrl(input alu_flags_t fl);
		psr_t                      nxt_psr;
		psr_t                      nxt_saved;
		logic [`EXEC_VECTOR_W-1:0] nxt_vec;
		logic [31:0]               nxt_fault;
		logic [31:0]               nxt_dfault;
		logic                      exc_any;
		exc_any = exc.exception_start || exc.irq_start || exc.data_abort ||
			exc.disable_irqs || exc.disable_mmu;
		nxt_vec = m_vec;
		nxt_psr = m_psr;
		nxt_saved = m_saved;
		nxt_fault = m_fault;
		nxt_dfault = m_dfault;
		if (dbg_writes(0))
			nxt_vec = dbg_val[31:VEC_LSB];
		else if (ins_writes(0))
			nxt_vec = req.ra[31:VEC_LSB];
		if (ins_writes(1)) begin
			nxt_psr = req.ra[7:0];
		end else if (dbg_writes(1)) begin
			nxt_psr = dbg_val[7:0];
		end else if (req.is_rfe) begin
			nxt_psr = m_saved;
		end else begin
			if (exc.disable_irqs)
				nxt_psr.irq_en = 1'b0;
			if (exc.disable_mmu)
				nxt_psr.tlb_en = 1'b0;
			if (req.update_flags) begin
				nxt_psr.z = fl.z;
				nxt_psr.n = fl.n;
				nxt_psr.o = fl.o;
			end
			if (req.update_carry)
				nxt_psr.c = fl.c;
		end
		if (dbg_writes(2))
			nxt_saved = dbg_val[7:0];
		else if (exc_any)
			nxt_saved = m_psr;
		else if (ins_writes(2))
			nxt_saved = req.ra[7:0];
		if (dbg_writes(3))
			nxt_fault = dbg_val;
		else if (exc.irq_start)
			nxt_fault = exc.fault_address;
		else if (exc.disable_irqs || exc.disable_mmu)
			nxt_fault = req.pc_plus_4;
		else if (ins_writes(3))
			nxt_fault = req.ra;
		if (dbg_writes(4))
			nxt_dfault = dbg_val;
		else if (exc.data_abort)
			nxt_dfault = m_mar; // Address of the last memory request.
		else if (ins_writes(4))
			nxt_dfault = req.ra;
		m_vec = nxt_vec;
		m_psr = nxt_psr;
		m_saved = nxt_saved;
		m_fault = nxt_fault;
		m_dfault = nxt_dfault;
	endtask

	// One request per cycle, checked on the next falling edge.
	task automatic run_cycle();
		logic [31:0] res;
		alu_flags_t  fl;
		logic [31:0] exp_wr_val;
		logic        exp_taken;
		logic        exp_stall;
		model_alu(req, res, fl);
		exp_wr_val = req.is_call ? req.pc_plus_4 : (req.mem_store ? req.rb : res);
		exp_taken = req.instr_class == CLASS_BRANCH &&
			(cond_met(req.branch_cc, m_psr) || req.is_swi || req.is_rfe);
		exp_stall = req.instr_class == CLASS_BRANCH || req.write_cr ||
			(req.instr_class == CLASS_MEM && req.alu_opc == ALU_OPC_GCR);
		update_ctrl(fl);
		if (req.mem_load || req.mem_store) begin
			m_width = req.mem_width;
			m_mar = res;
		end
		if (req.mem_store)
			m_mdr = req.rb;
		@(negedge clk);
		check_value("alu_out", res, o_out.alu_out);
		check_value("wr_val", exp_wr_val, o_out.wr_val);
		check_value("wr_result", req.update_rd, o_out.wr_result);
		check_value("rd_sel", req.rd_sel, o_out.rd_sel);
		check_value("branch_taken", exp_taken, o_out.branch_taken);
		check_value("stall_clear", exp_stall, o_out.stall_clear);
		check_value("valid", req.valid, o_out.valid);
		check_value("load", req.mem_load, o_mem.load);
		check_value("store", req.mem_store, o_mem.store);
		check_value("wr_en", req.mem_store, o_mem.wr_en);
		if (!$isunknown(m_mar)) begin
			check_value("mar", m_mar, o_mem.mar);
			check_value("width", m_width, o_mem.width);
		end
		if (!$isunknown(m_mdr))
			check_value("mdr", m_mdr, o_mem.mdr);
		check_value("psr", m_psr, o_psr);
		check_value("vector_base", m_vec, o_vector_base);
		check_value("dbg_cr_val", cr_read(dbg_sel), o_dbg_cr_val);
	endtask

	function automatic exec_req_t idle_req();
		exec_req_t r;
		r = '0;
		return r;
	endfunction

	function automatic exec_req_t random_req();
		exec_req_t r;
		r.ra = $urandom;
		r.rb = $urandom;
		r.imm32 = $urandom;
		r.pc_plus_4 = $urandom;
		r.rd_sel = 4'($urandom);
		r.update_rd = 1'($urandom);
		r.alu_opc = alu_opc_t'(5'($urandom_range(0, 23))); // Some undefined codes too.
		r.op1_ra = 1'($urandom);
		r.op1_rb = 1'($urandom);
		r.op2_rb = 1'($urandom);
		r.mem_load = 1'($urandom);
		r.mem_store = 1'($urandom);
		r.mem_width = 2'($urandom);
		r.branch_cc = branch_cc_t'(4'($urandom));
		r.instr_class = instr_class_t'(2'($urandom));
		r.update_carry = 1'($urandom);
		r.update_flags = 1'($urandom);
		r.is_call = 1'($urandom);
		r.is_swi = 1'($urandom);
		r.is_rfe = $urandom_range(0, 15) == 0;
		r.valid = 1'b1;
		r.cr_sel = 3'($urandom);
		r.write_cr = $urandom_range(0, 7) == 0;
		return r;
	endfunction

	// Returns in the time step in which reset falls.
	task automatic wait_reset_release(output logic ok);
		ok = 1'b0;
		for (int i = 0; i < 20 && !ok; i++) begin
			@(negedge clk or negedge rst);
			ok = rst === 1'b0;
		end
	endtask

	task automatic test_reset();
		test_name = "reset";
		req = idle_req();
		exc = '0;
		dbg_en = 1'b0;
		dbg_val = '0;
		check_value("wr_result", 0, o_out.wr_result);
		check_value("branch_taken", 0, o_out.branch_taken);
		check_value("stall_clear", 0, o_out.stall_clear);
		check_value("valid", 0, o_out.valid);
		check_value("load", 0, o_mem.load);
		check_value("store", 0, o_mem.store);
		check_value("wr_en", 0, o_mem.wr_en);
		check_value("psr", 0, o_psr);
		for (int s = 0; s < 5; s++) begin
			dbg_sel = 3'(s);
			run_cycle();
			check_value("cr after reset", 0, o_dbg_cr_val);
		end
	endtask

	task automatic test_alu_random();
		test_name = "alu_random";
		for (int k = 0; k < 200; k++) begin
			req = random_req();
			dbg_sel = 3'($urandom);
			run_cycle();
		end
	endtask

	task automatic test_flags_branches();
		test_name = "flags_branches";
		for (int k = 0; k < 12; k++) begin
			req = idle_req();
			req.valid = 1'b1;
			req.op1_ra = 1'b1;
			req.op2_rb = 1'b1;
			req.update_flags = 1'b1;
			req.update_carry = 1'b1;
			req.alu_opc = k % 3 == 0 ? ALU_OPC_CMP : (k % 3 == 1 ? ALU_OPC_ADD : ALU_OPC_SUB);
			req.ra = $urandom;
			req.rb = $urandom;
			if (k % 4 == 0)
				req.rb = req.ra; // Equal operands.
			else if (k % 4 == 1)
				req.ra = 32'($urandom_range(0, 16)) - 32'd8; // Small signed values.
			else if (k % 4 == 2)
				req.rb = req.rb & 32'h7fffffff;
			run_cycle();
			for (int cc = 0; cc < 16; cc++) begin
				req = idle_req();
				req.valid = 1'b1;
				req.instr_class = CLASS_BRANCH;
				req.branch_cc = branch_cc_t'(4'(cc));
				req.pc_plus_4 = $urandom;
				req.imm32 = $urandom;
				run_cycle();
				check_value("branch stall_clear", 1, o_out.stall_clear);
			end
		end
	endtask

	task automatic read_back_all();
		for (int s = 0; s < 8; s++) begin
			req = idle_req();
			req.valid = 1'b1;
			req.instr_class = CLASS_MEM;
			req.alu_opc = ALU_OPC_GCR;
			req.cr_sel = 3'(s);
			dbg_sel = 3'(s);
			run_cycle();
			if (s > 4) begin
				check_value("unused cr gcr", 0, o_out.alu_out);
				check_value("unused cr dbg", 0, o_dbg_cr_val);
			end
		end
	endtask

	task automatic test_ctrl_regs();
		test_name = "ctrl_regs";
		for (int mode = 0; mode < 3; mode++) begin
			// Instruction only, debug only, then both at once.
			for (int s = 0; s < 8; s++) begin
				req = idle_req();
				req.valid = 1'b1;
				req.instr_class = CLASS_OTHER;
				req.write_cr = mode != 1;
				req.cr_sel = 3'(s);
				req.ra = $urandom;
				dbg_en = mode != 0;
				dbg_sel = 3'(s);
				dbg_val = $urandom;
				run_cycle();
			end
			dbg_en = 1'b0;
			read_back_all();
		end
	endtask

	task automatic test_exceptions();
		test_name = "exceptions";
		req = idle_req();
		req.write_cr = 1'b1;
		req.cr_sel = 3'd1;
		req.ra = 32'h000000f0 | ($urandom & 32'h0000000f); // All enables set.
		run_cycle();
		req = idle_req();
		req.instr_class = CLASS_MEM;
		req.mem_load = 1'b1;
		req.op1_ra = 1'b1;
		req.ra = $urandom;
		req.imm32 = $urandom;
		req.mem_width = 2'd2;
		run_cycle();
		req = idle_req();
		exc.data_abort = 1'b1;
		dbg_sel = 3'd4;
		run_cycle();
		exc = '0;
		exc.irq_start = 1'b1;
		exc.fault_address = $urandom;
		dbg_sel = 3'd3;
		run_cycle();
		exc = '0;
		exc.disable_irqs = 1'b1;
		req.pc_plus_4 = $urandom;
		dbg_sel = 3'd2;
		run_cycle();
		check_value("irq_en cleared", 0, o_psr.irq_en);
		exc = '0;
		req = idle_req();
		req.valid = 1'b1;
		req.instr_class = CLASS_BRANCH;
		req.alu_opc = ALU_OPC_RFE;
		req.is_rfe = 1'b1;
		run_cycle();
		check_value("rfe branch_taken", 1, o_out.branch_taken);
		check_value("irq_en restored", 1, o_psr.irq_en);
		req = idle_req();
		req.pc_plus_4 = $urandom;
		exc.exception_start = 1'b1;
		exc.disable_mmu = 1'b1;
		dbg_sel = 3'd3;
		run_cycle();
		check_value("tlb_en cleared", 0, o_psr.tlb_en);
		exc = '0;
	endtask

	task automatic test_mem_requests();
		test_name = "mem_requests";
		for (int k = 0; k < 60; k++) begin
			req = idle_req();
			req.valid = 1'b1;
			req.op1_ra = 1'b1;
			req.ra = $urandom;
			req.rb = $urandom;
			req.imm32 = $urandom;
			req.mem_width = 2'($urandom);
			case ($urandom_range(0, 2))
			0: begin
				req.instr_class = CLASS_MEM;
				req.mem_load = 1'b1;
				req.update_rd = 1'b1;
			end
			1: begin
				req.instr_class = CLASS_MEM;
				req.mem_store = 1'b1;
			end
			default: begin
				req.alu_opc = ALU_OPC_XOR; // Memory request must hold.
				req.op2_rb = 1'b1;
				req.update_rd = 1'b1;
			end
			endcase
			run_cycle();
		end
	endtask

	initial begin
		req = '0;
		req.valid = 1'b1; // Busy request held through reset.
		req.update_rd = 1'b1;
		req.instr_class = CLASS_BRANCH;
		req.branch_cc = BRANCH_CC_B;
		req.mem_load = 1'b1;
		req.mem_store = 1'b1;
		req.write_cr = 1'b1;
		req.cr_sel = 3'd1;
		req.ra = '1;
		exc = '0;
		exc.irq_start = 1'b1;
		exc.fault_address = '1;
		dbg_sel = '0;
		dbg_val = '1;
		dbg_en = 1'b1;
		m_vec = '0;
		m_psr = '0;
		m_saved = '0;
		m_fault = '0;
		m_dfault = '0;
		m_mar = 'x;
		m_mdr = 'x;
		m_width = 'x;
		checks = 0;
		errors = 0;
		test_name = "init";
		seed_val = $urandom(32'h188acaa0);
		wait_reset_release(released);
		if (!released) begin
			$display("Reset was still asserted after 20 clock cycles.");
			errors++;
		end else begin
			test_reset();
			test_alu_random();
			test_flags_branches();
			test_ctrl_regs();
			test_exceptions();
			test_mem_requests();
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_branch_cond.sv
logic/exec_ctrl_regs.sv
logic/exec_result_reg.sv
logic/exec_stage.sv
tests/exec_clock_gen.sv
tests/exec_stage_tb.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/exec_pkg.sv
      - logic/exec_alu.sv
      - logic/exec_branch_cond.sv
      - logic/exec_ctrl_regs.sv
      - logic/exec_result_reg.sv
      - logic/exec_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/exec_clock_gen.sv
      - tests/exec_stage_tb.sv
